//--- flist.f
+incdir+tb
hw/dbg_pkg.sv
hw/packet_buffer.sv
hw/host_ingress.sv
hw/host_egress.sv
hw/host_interface.sv
tb/tb_host_interface.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the debug host bridge testbench with Verilator and runs it.
# The run fails if the log holds the fail message or the simulator errors out.

cd "$(dirname "$0")" || exit 1
mkdir -p build || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_host_interface -Mdir build/obj -f flist.f \
   > build/compile.log 2>&1 \
   || { echo "Verilator build failed, see build/compile.log"; exit 1; }

./build/obj/Vtb_host_interface > build/sim.log 2>&1
status=$?
cat build/sim.log

grep -q "=== FAIL ===" build/sim.log && { echo "Simulation failed"; exit 1; }
[ "$status" -eq 0 ] || { echo "Simulator exited with status $status"; exit 1; }
echo "Simulation passed"

//--- tb/tb_packets.svh
// Packet stimulus table for the debug host bridge testbench
//
// One row per packet: the direction it travels and its payload length.
// Both directions see lengths 1, 2, 5, 12 and 12, with the 12-word
// packets and the single-word packets sent back to back.

`ifndef TB_PACKETS_SVH
`define TB_PACKETS_SVH

// Host link to debug interconnect, or debug interconnect to host link
localparam bit TO_DBG  = 1'b0;
localparam bit TO_HOST = 1'b1;

localparam int NUM_PKTS = 10;

// Direction of each packet
localparam bit PKT_DIR [NUM_PKTS] = '{
   TO_DBG,
   TO_HOST,
   TO_DBG,
   TO_HOST,
   TO_DBG,
   TO_HOST,
   TO_DBG,
   TO_HOST,
   TO_DBG,
   TO_HOST
};

// Payload length of each packet, which is also the host header value
localparam int PKT_LEN [NUM_PKTS] = '{
   1,
   12,
   12,
   1,
   12,
   5,
   2,
   12,
   5,
   2
};

`endif

//--- tb/tb_host_interface.sv
// Testbench for the debug host bridge
//
// Sends host packets and debug packets from the stimulus table at the same
// time, with random ready on both outputs. Scoreboards check deframing,
// framing, ordering and store-and-forward release in both directions.

`timescale 1ns/100ps
`default_nettype none

module tb_host_interface;

   import dbg_pkg::*;

   `include "tb_packets.svh"

   localparam int          MAX_LEN = 12;
   localparam logic [31:0] SEED    = 32'd51122;
   localparam int          P_ING   = 0;
   localparam int          P_EGR   = 1;
   localparam int          P_GEN   = 2;

   function automatic int table_words();
      int sum;
      sum = 0;
      for (int i = 0; i < NUM_PKTS; i++) begin
         sum += PKT_LEN[i];
      end
      return sum;
   endfunction

   localparam int TIMEOUT_CYCLES = table_words() * 8 + 1000;

   logic              clk;
   logic              rst;
   logic [WORD_W-1:0] host_in_data;
   logic              host_in_valid;
   logic              host_in_ready;
   logic [WORD_W-1:0] host_out_data;
   logic              host_out_valid;
   logic              host_out_ready = 1'b0;
   logic [WORD_W-1:0] dbg_out_data;
   logic              dbg_out_last;
   logic              dbg_out_valid;
   logic              dbg_out_ready = 1'b0;
   logic [WORD_W-1:0] dbg_in_data;
   logic              dbg_in_last;
   logic              dbg_in_valid;
   logic              dbg_in_ready;

   // Expected payload words and lengths, one pair of queues per direction
   logic [WORD_W-1:0] ing_exp_data [$];
   logic [WORD_W-1:0] egr_exp_data [$];
   int                ing_exp_len [$];
   int                egr_exp_len [$];

   int errs [3] = '{0, 0, 0};
   int cycles = 0;
   int ing_total;
   int egr_total;
   // Position in the packet leaving each output, and that packet's length
   int ing_pos = 0;
   int egr_pos = 0;
   int ing_cur_len = 0;
   int egr_cur_len = 0;
   int ing_pkts_out = 0;
   int egr_pkts_out = 0;
   int ing_pkts_rx = 0;
   int egr_pkts_rx = 0;
   int host_rem = 0;
   int host_pkts_done = 0;
   int dbg_pkts_done = 0;
   // Flits held in each buffer, counted from the transfers on both sides
   int ing_fill = 0;
   int egr_fill = 0;
   int rst_tail = 0;
   logic [31:0] rng_host = SEED;
   logic [31:0] rng_dbg = SEED;
   logic [31:0] rng_ready = SEED;

   host_interface #(.MAX_PKT_LEN(MAX_LEN)) i_dut (
      .clk            (clk),
      .rst            (rst),
      .host_in_data   (host_in_data),
      .host_in_valid  (host_in_valid),
      .host_in_ready  (host_in_ready),
      .host_out_data  (host_out_data),
      .host_out_valid (host_out_valid),
      .host_out_ready (host_out_ready),
      .dbg_out_data   (dbg_out_data),
      .dbg_out_last   (dbg_out_last),
      .dbg_out_valid  (dbg_out_valid),
      .dbg_out_ready  (dbg_out_ready),
      .dbg_in_data    (dbg_in_data),
      .dbg_in_last    (dbg_in_last),
      .dbg_in_valid   (dbg_in_valid),
      .dbg_in_ready   (dbg_in_ready)
   );

   function automatic logic [31:0] lcg_step(input logic [31:0] state);
      return state * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic value_error(input int path, input string msg);
      $display("[FAIL] time %0t: %s", $time, msg);
      errs[path]++;
   endtask

   task automatic plain_error(input int path, input string msg);
      $display("Error at time %0t: %s", $time, msg);
      errs[path]++;
   endtask

   task automatic print_counts();
      $display("Errors: ingress %0d, egress %0d, general %0d, total %0d",
               errs[P_ING], errs[P_EGR], errs[P_GEN], errs[P_ING] + errs[P_EGR] + errs[P_GEN]);
   endtask

   // Holds the word on the host link until the DUT takes it
   task automatic send_host_word(input logic [WORD_W-1:0] word);
      logic moved;
      host_in_data  <= word;
      host_in_valid <= 1'b1;
      moved = 1'b0;
      while (!moved) begin
         @(negedge clk);
         moved = host_in_valid && host_in_ready;
         @(posedge clk);
      end
   endtask

   task automatic send_dbg_flit(input logic [WORD_W-1:0] word, input logic last);
      logic moved;
      dbg_in_data  <= word;
      dbg_in_last  <= last;
      dbg_in_valid <= 1'b1;
      moved = 1'b0;
      while (!moved) begin
         @(negedge clk);
         moved = dbg_in_valid && dbg_in_ready;
         @(posedge clk);
      end
   endtask

   task automatic send_host_packets();
      for (int i = 0; i < NUM_PKTS; i++) begin
         if (PKT_DIR[i] == TO_DBG) begin
            ing_exp_len.push_back(PKT_LEN[i]);
            send_host_word(WORD_W'(PKT_LEN[i]));
            for (int j = 0; j < PKT_LEN[i]; j++) begin
               rng_host = lcg_step(rng_host);
               ing_exp_data.push_back(rng_host[31:16]);
               send_host_word(rng_host[31:16]);
            end
         end
      end
      host_in_valid <= 1'b0;
   endtask

   task automatic send_dbg_packets();
      for (int i = 0; i < NUM_PKTS; i++) begin
         if (PKT_DIR[i] == TO_HOST) begin
            egr_exp_len.push_back(PKT_LEN[i]);
            for (int j = 0; j < PKT_LEN[i]; j++) begin
               rng_dbg = lcg_step(rng_dbg);
               egr_exp_data.push_back(rng_dbg[31:16]);
               send_dbg_flit(rng_dbg[31:16], j == PKT_LEN[i] - 1);
            end
         end
      end
      dbg_in_valid <= 1'b0;
      dbg_in_last  <= 1'b0;
   endtask

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Random back-pressure on both outputs, ready about three cycles in four
   always @(posedge clk) begin
      if (rst) begin
         rng_ready = SEED;
      end else begin
         rng_ready = lcg_step(rng_ready);
         dbg_out_ready  <= rng_ready[24] | rng_ready[25];
         host_out_ready <= rng_ready[26] | rng_ready[27];
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles: table not finished, %0d of %0d packets delivered",
                  cycles, ing_pkts_rx + egr_pkts_rx, ing_total + egr_total);
         print_counts();
         $display("=== FAIL ===");
         $finish;
      end
   end

   // Outputs are sampled at the falling edge, where they are stable.
   // Store-and-forward and ready checks use the counts from before this cycle's transfers
   always @(negedge clk) begin : monitor
      logic [WORD_W-1:0] exp_word;
      if ((rst || rst_tail != 0) && (dbg_out_valid || host_out_valid)) begin
         value_error(P_GEN, "output valid high during or right after reset");
      end
      rst_tail = rst ? 1 : 0;
      if (!rst) begin
         if (dbg_out_valid && ing_pos == 0 && ing_pkts_out >= host_pkts_done) begin
            value_error(P_ING, "dbg_out_valid before the host sent the last payload word");
         end
         if (host_out_valid && egr_pos == 0 && egr_pkts_out >= dbg_pkts_done) begin
            value_error(P_EGR, "host_out_valid before dbg_in sent the last flit");
         end
         // A header word never waits, payload waits only on a full buffer
         if (host_rem == 0 && !host_in_ready) begin
            value_error(P_ING, "host_in_ready low while a header word is due");
         end
         if (host_rem != 0 && ing_fill == MAX_LEN && host_in_ready) begin
            value_error(P_ING, "host_in_ready high with the ingress buffer full");
         end
         if (egr_fill == MAX_LEN && dbg_in_ready) begin
            value_error(P_EGR, "dbg_in_ready high with the egress buffer full");
         end
         if (dbg_out_valid && dbg_out_ready) begin
            ing_fill--;
            if (ing_pos == 0 && ing_exp_len.size() == 0) begin
               plain_error(P_ING, "a flit came out on debug out with no packet expected");
            end else begin
               if (ing_pos == 0) begin
                  ing_cur_len = ing_exp_len.pop_front();
                  ing_pkts_out++;
               end
               exp_word = ing_exp_data.pop_front();
               if (dbg_out_data != exp_word) begin
                  value_error(P_ING, $sformatf("dbg_out_data %h, expected %h",
                                               dbg_out_data, exp_word));
               end
               ing_pos++;
               if (dbg_out_last != (ing_pos == ing_cur_len)) begin
                  value_error(P_ING, $sformatf("dbg_out_last %b on flit %0d of %0d",
                                               dbg_out_last, ing_pos, ing_cur_len));
               end
               if (ing_pos == ing_cur_len) begin
                  ing_pos = 0;
                  ing_pkts_rx++;
               end
            end
         end
         if (host_out_valid && host_out_ready) begin
            if (egr_pos == 0 && egr_exp_len.size() == 0) begin
               plain_error(P_EGR, "a word came out on host out with no packet expected");
            end else if (egr_pos == 0) begin
               egr_cur_len = egr_exp_len.pop_front();
               egr_pkts_out++;
               if (host_out_data != WORD_W'(egr_cur_len)) begin
                  value_error(P_EGR, $sformatf("header %0d, expected %0d",
                                               host_out_data, egr_cur_len));
               end
               egr_pos = 1;
            end else begin
               egr_fill--;
               exp_word = egr_exp_data.pop_front();
               if (host_out_data != exp_word) begin
                  value_error(P_EGR, $sformatf("host_out_data %h, expected %h",
                                               host_out_data, exp_word));
               end
               egr_pos++;
               if (egr_pos == egr_cur_len + 1) begin
                  egr_pos = 0;
                  egr_pkts_rx++;
               end
            end
         end
         // Input side: a header opens a host packet, its Nth payload word closes it
         if (host_in_valid && host_in_ready) begin
            if (host_rem == 0) begin
               host_rem = int'(host_in_data);
            end else begin
               ing_fill++;
               host_rem--;
               if (host_rem == 0) begin
                  host_pkts_done++;
               end
            end
         end
         if (dbg_in_valid && dbg_in_ready) begin
            egr_fill++;
            if (dbg_in_last) begin
               dbg_pkts_done++;
            end
         end
      end
   end

   initial begin
      rst           = 1'b1;
      host_in_data  = '0;
      host_in_valid = 1'b0;
      dbg_in_data   = '0;
      dbg_in_last   = 1'b0;
      dbg_in_valid  = 1'b0;
      ing_total     = 0;
      egr_total     = 0;
      for (int i = 0; i < NUM_PKTS; i++) begin
         if (PKT_DIR[i] == TO_DBG) begin
            ing_total++;
         end else begin
            egr_total++;
         end
      end
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      fork
         send_host_packets();
         send_dbg_packets();
      join
      wait (ing_pkts_rx == ing_total && egr_pkts_rx == egr_total);
      repeat (4) @(posedge clk);
      @(negedge clk);
      if (dbg_out_valid || host_out_valid) begin
         plain_error(P_GEN, "an output still offered data after the last expected packet");
      end
      print_counts();
      if (errs[P_ING] + errs[P_EGR] + errs[P_GEN] == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- hw/host_interface.sv
// Debug host interface bridge
//
// Ingress path: host words are deframed and stored in a packet buffer
// that drives the debug output. Egress path: debug packets are stored in
// a second buffer and framed with a length word toward the host.

`timescale 1ns/100ps
`default_nettype none

module host_interface #(
   parameter int MAX_PKT_LEN = 12
) (
   input  logic                         clk,
   input  logic                         rst,

   input  logic [dbg_pkg::WORD_W-1:0]   host_in_data,
   input  logic                         host_in_valid,
   output logic                         host_in_ready,

   output logic [dbg_pkg::WORD_W-1:0]   host_out_data,
   output logic                         host_out_valid,
   input  logic                         host_out_ready,

   output logic [dbg_pkg::WORD_W-1:0]   dbg_out_data,
   output logic                         dbg_out_last,
   output logic                         dbg_out_valid,
   input  logic                         dbg_out_ready,

   input  logic [dbg_pkg::WORD_W-1:0]   dbg_in_data,
   input  logic                         dbg_in_last,
   input  logic                         dbg_in_valid,
   output logic                         dbg_in_ready
);

   import dbg_pkg::*;

   localparam int LEN_W = $clog2(MAX_PKT_LEN + 1);

   logic [WORD_W-1:0] ing_data;
   logic              ing_last;
   logic              ing_valid;
   logic              ing_ready;

   logic [WORD_W-1:0] egr_data;
   logic              egr_last;
   logic              egr_valid;
   logic              egr_ready;
   logic [LEN_W-1:0]  egr_head_len;

   host_ingress #(.MAX_PKT_LEN(MAX_PKT_LEN)) u_host_ingress (
      .clk           (clk),
      .rst           (rst),
      .host_in_data  (host_in_data),
      .host_in_valid (host_in_valid),
      .host_in_ready (host_in_ready),
      .flit_data     (ing_data),
      .flit_last     (ing_last),
      .flit_valid    (ing_valid),
      .flit_ready    (ing_ready)
   );

   packet_buffer #(.DEPTH(MAX_PKT_LEN)) u_ingress_buffer (
      .clk       (clk),
      .rst       (rst),
      .in_data   (ing_data),
      .in_last   (ing_last),
      .in_valid  (ing_valid),
      .in_ready  (ing_ready),
      .out_data  (dbg_out_data),
      .out_last  (dbg_out_last),
      .out_valid (dbg_out_valid),
      .out_ready (dbg_out_ready),
      .head_len  ()
   );

   packet_buffer #(.DEPTH(MAX_PKT_LEN)) u_egress_buffer (
      .clk       (clk),
      .rst       (rst),
      .in_data   (dbg_in_data),
      .in_last   (dbg_in_last),
      .in_valid  (dbg_in_valid),
      .in_ready  (dbg_in_ready),
      .out_data  (egr_data),
      .out_last  (egr_last),
      .out_valid (egr_valid),
      .out_ready (egr_ready),
      .head_len  (egr_head_len)
   );

   host_egress #(.MAX_PKT_LEN(MAX_PKT_LEN)) u_host_egress (
      .clk            (clk),
      .rst            (rst),
      .flit_data      (egr_data),
      .flit_last      (egr_last),
      .flit_valid     (egr_valid),
      .flit_ready     (egr_ready),
      .head_len       (egr_head_len),
      .host_out_data  (host_out_data),
      .host_out_valid (host_out_valid),
      .host_out_ready (host_out_ready)
   );

   // Between host packets the ingress buffer holds no partial packet
   a_ingress_realign: assert property (@(posedge clk) disable iff (rst)
      (u_host_ingress.state == ING_HEADER) |-> (u_ingress_buffer.open_len == '0));

endmodule

`default_nettype wire

//--- hw/host_egress.sv
// Host egress framer
//
// Sends a length word to the host ahead of every debug packet, then the
// packet's flits. The length comes from the buffer that holds the packet,
// which offers a packet only once it is complete.

`timescale 1ns/100ps
`default_nettype none

module host_egress #(
   parameter int MAX_PKT_LEN = 12
) (
   input  logic                                clk,
   input  logic                                rst,

   input  logic [dbg_pkg::WORD_W-1:0]          flit_data,
   input  logic                                flit_last,
   input  logic                                flit_valid,
   output logic                                flit_ready,

   input  logic [$clog2(MAX_PKT_LEN+1)-1:0]    head_len,

   output logic [dbg_pkg::WORD_W-1:0]          host_out_data,
   output logic                                host_out_valid,
   input  logic                                host_out_ready
);

   import dbg_pkg::*;

   egress_state_t state;
   logic          header_xfer;
   logic          last_xfer;

   // The header word is offered as soon as a complete packet is shown
   assign host_out_valid = flit_valid;
   assign host_out_data  = (state == EGR_HEADER) ? WORD_W'(head_len) : flit_data;
   assign flit_ready     = (state == EGR_PAYLOAD) & host_out_ready;

   assign header_xfer = (state == EGR_HEADER) & flit_valid & host_out_ready;
   assign last_xfer   = flit_valid & flit_ready & flit_last;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= EGR_HEADER;
      end else begin
         case (state)
            EGR_HEADER: begin
               if (header_xfer) begin
                  state <= EGR_PAYLOAD;
               end
            end
            EGR_PAYLOAD: begin
               if (last_xfer) begin
                  state <= EGR_HEADER;
               end
            end
            default: state <= EGR_HEADER;
         endcase
      end
   end

   // A complete packet at the buffer head always has a length
   a_head_len: assert property (@(posedge clk) disable iff (rst)
      (state == EGR_HEADER && flit_valid) |-> (head_len != '0));

endmodule

`default_nettype wire

//--- hw/host_ingress.sv
// Host ingress deframer
//
// Consumes the length word that opens each host packet and forwards the
// following payload words as a debug packet, marking the final word with
// last. The data path is combinational with no added latency.

`timescale 1ns/100ps
`default_nettype none

module host_ingress #(
   parameter int MAX_PKT_LEN = 12
) (
   input  logic                         clk,
   input  logic                         rst,

   input  logic [dbg_pkg::WORD_W-1:0]   host_in_data,
   input  logic                         host_in_valid,
   output logic                         host_in_ready,

   output logic [dbg_pkg::WORD_W-1:0]   flit_data,
   output logic                         flit_last,
   output logic                         flit_valid,
   input  logic                         flit_ready
);

   import dbg_pkg::*;

   localparam int LEN_W = $clog2(MAX_PKT_LEN + 1);

   ingress_state_t   state;
   // Payload words still to come, including the one on the link
   logic [LEN_W-1:0] remaining;
   logic             host_xfer;

   assign host_in_ready = (state == ING_HEADER) ? 1'b1 : flit_ready;
   assign host_xfer     = host_in_valid & host_in_ready;

   assign flit_data  = host_in_data;
   assign flit_valid = (state == ING_PAYLOAD) & host_in_valid;
   assign flit_last  = (state == ING_PAYLOAD) & (remaining == LEN_W'(1));

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= ING_HEADER;
         remaining <= '0;
      end else if (host_xfer) begin
         case (state)
            ING_HEADER: begin
               remaining <= host_in_data[LEN_W-1:0];
               state     <= ING_PAYLOAD;
            end
            ING_PAYLOAD: begin
               remaining <= remaining - 1'b1;
               if (remaining == LEN_W'(1)) begin
                  state <= ING_HEADER;
               end
            end
            default: state <= ING_HEADER;
         endcase
      end
   end

   // Zero-length or oversized headers are a protocol violation
   a_header_len: assert property (@(posedge clk) disable iff (rst)
      (state == ING_HEADER && host_in_valid) |->
         (host_in_data != '0 && host_in_data <= WORD_W'(MAX_PKT_LEN)));

endmodule

`default_nettype wire

//--- hw/packet_buffer.sv
// Store-and-forward packet buffer
//
// Circular buffer of flits (data plus last marker). A packet is offered
// on the output only once its last flit has been stored, and output
// valid stays high until that packet has drained. The length of the
// packet at the head is reported on head_len.

`timescale 1ns/100ps
`default_nettype none

module packet_buffer #(
   parameter int DEPTH = 12
) (
   input  logic                         clk,
   input  logic                         rst,

   input  logic [dbg_pkg::WORD_W-1:0]   in_data,
   input  logic                         in_last,
   input  logic                         in_valid,
   output logic                         in_ready,

   output logic [dbg_pkg::WORD_W-1:0]   out_data,
   output logic                         out_last,
   output logic                         out_valid,
   input  logic                         out_ready,

   output logic [$clog2(DEPTH+1)-1:0]   head_len
);

   import dbg_pkg::*;

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [WORD_W-1:0] mem_data [DEPTH];
   logic              mem_last [DEPTH];

   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   // Flits stored, and complete packets among them
   logic [CNT_W-1:0]  count;
   logic [CNT_W-1:0]  pkt_count;
   // Flits written so far of the packet still being received
   logic [CNT_W-1:0]  open_len;

   logic wr_en;
   logic rd_en;
   logic pkt_in;
   logic pkt_out;

   // Pointers wrap at DEPTH, which need not be a power of two
   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
      logic [PTR_W-1:0] nxt;
      if (ptr == PTR_W'(DEPTH - 1)) begin
         nxt = '0;
      end else begin
         nxt = ptr + 1'b1;
      end
      return nxt;
   endfunction

   assign in_ready  = (count != CNT_W'(DEPTH));
   assign out_valid = (pkt_count != '0);
   assign out_data  = mem_data[rd_ptr];
   assign out_last  = mem_last[rd_ptr];

   assign wr_en   = in_valid & in_ready;
   assign rd_en   = out_valid & out_ready;
   assign pkt_in  = wr_en & in_last;
   assign pkt_out = rd_en & out_last;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem_data[wr_ptr] <= in_data;
         mem_last[wr_ptr] <= in_last;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         pkt_count <= '0;
         open_len  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= ptr_next(wr_ptr);
         end
         if (rd_en) begin
            rd_ptr <= ptr_next(rd_ptr);
         end
         count     <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
         // A packet becomes visible the cycle after its last flit is stored
         pkt_count <= pkt_count + CNT_W'(pkt_in) - CNT_W'(pkt_out);
         if (pkt_in) begin
            open_len <= '0;
         end else if (wr_en) begin
            open_len <= open_len + 1'b1;
         end
      end
   end

   // Walk forward from the read pointer to the first stored last marker
   always_comb begin : head_search
      logic found;
      int   idx;
      found    = 1'b0;
      head_len = '0;
      for (int i = 0; i < DEPTH; i++) begin
         idx = int'(rd_ptr) + i;
         if (idx >= DEPTH) begin
            idx = idx - DEPTH;
         end
         if (!found && (i < int'(count)) && mem_last[idx]) begin
            found    = 1'b1;
            head_len = CNT_W'(i + 1);
         end
      end
   end

   // A write may land on the read entry only while the buffer is empty
   a_no_write_full: assert property (@(posedge clk) disable iff (rst)
      (wr_en && (wr_ptr == rd_ptr)) |-> (count == '0));

   // The DEPTH-th flit of a packet must close it, or the buffer deadlocks
   a_pkt_fits: assert property (@(posedge clk) disable iff (rst)
      (wr_en && (open_len == CNT_W'(DEPTH - 1))) |-> in_last);

endmodule

`default_nettype wire

//--- hw/dbg_pkg.sv
// Debug host bridge shared definitions
//
// Holds the word width of the host link and of debug flits, and the
// state encodings of the ingress deframer and the egress framer.

`default_nettype none

package dbg_pkg;

   // Width of one host word and of the data field of one debug flit
   localparam int WORD_W = 16;

   // Ingress deframer states
   typedef enum logic {
      // Waiting for the length word of the next host packet
      ING_HEADER,
      // Forwarding payload words as debug flits
      ING_PAYLOAD
   } ingress_state_t;

   // Egress framer states
   typedef enum logic {
      // Length word of the head packet is pending on the host link
      EGR_HEADER,
      // Forwarding the flits of the head packet
      EGR_PAYLOAD
   } egress_state_t;

endpackage

`default_nettype wire
